/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// data widths
`define CACHE_ADDR_BITS 30 // word address
`define CPU_DATA_BITS   32
`define MEM_DATA_BITS   128

// geometry
`define CACHE_SETS      32
`define CACHE_WAYS      2
`define BEATS_PER_LINE  4
`define WORDS_PER_BEAT  (`MEM_DATA_BITS / `CPU_DATA_BITS)

// word address split into tag, index, beat and word from the msb down
`define INDEX_BITS      5
`define BEAT_BITS       2
`define WORD_BITS       2
`define TAG_BITS        (`CACHE_ADDR_BITS - `INDEX_BITS - `BEAT_BITS - `WORD_BITS)

// memory side addresses whole beats
`define MEM_ADDR_BITS   (`CACHE_ADDR_BITS - `WORD_BITS)

`endif

/* src/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CPU_DATA_BITS-1:0] word_t;
    typedef logic [`MEM_DATA_BITS-1:0] beat_t;

    typedef struct packed {
        logic [`TAG_BITS-1:0]   tag;
        logic [`INDEX_BITS-1:0] index;
        logic [`BEAT_BITS-1:0]  beat;  // beat within the line
        logic [`WORD_BITS-1:0]  word;  // word within the beat
    } addr_fields_t;

    typedef struct packed {
        addr_fields_t                addr;
        word_t                       data;
        logic [`CPU_DATA_BITS/8-1:0] wmask; // all zero for a read
    } cpu_req_t;

    typedef struct packed {
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic                      rw;  // 1 = write
    } mem_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`TAG_BITS-1:0] tag;
    } way_meta_t;

    // lru names the way to evict next
    typedef struct packed {
        way_meta_t [`CACHE_WAYS-1:0] way;
        logic                        lru;
    } set_meta_t;

    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim_way;
        logic victim_dirty;
    } lookup_t;

endpackage

/* src/cache_sram.sv */
`timescale 1ns/10ps

module cache_sram #(
    parameter int  DEPTH     = 32,
    parameter type payload_t = logic
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] index,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];

    // single port with a registered read-out
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
            rdata      <= wdata; // write-first
        end else begin
            rdata <= mem[index];
        end
    end

endmodule

/* src/cache_decode.sv */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_decode (
    input  cache_pkg::addr_fields_t addr,
    input  cache_pkg::set_meta_t    meta,
    output cache_pkg::lookup_t      lookup
);

    logic [`CACHE_WAYS-1:0] way_valid;
    logic [`CACHE_WAYS-1:0] way_hit;
    logic                   victim;

    // tag compare in every way
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            way_valid[w] = meta.way[w].valid;
            way_hit[w]   = way_valid[w] && (meta.way[w].tag == addr.tag);
        end
    end

    // empty ways get filled before anything is evicted
    always_comb begin
        if (!way_valid[0])
            victim = 1'b0;
        else if (!way_valid[1])
            victim = 1'b1;
        else
            victim = meta.lru;
    end

    always_comb begin
        lookup.hit          = |way_hit;
        lookup.hit_way      = way_hit[1]; // way 0 unless way 1 matched
        lookup.victim_way   = victim;
        lookup.victim_dirty = way_valid[victim] && meta.way[victim].dirty;
    end

endmodule

/* src/cache_execute.sv */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_execute (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cpu_req_valid,
    input  cache_pkg::cpu_req_t               cpu_req,
    output logic                              cpu_req_ready,
    output cache_pkg::addr_fields_t           addr,
    input  cache_pkg::lookup_t                lookup,
    input  cache_pkg::set_meta_t              meta_rdata,
    output logic                              meta_we,
    output cache_pkg::set_meta_t              meta_wdata,
    output logic [`INDEX_BITS+`BEAT_BITS-1:0] data_index,
    output logic [`CACHE_WAYS-1:0]            data_we,
    output cache_pkg::beat_t                  data_wdata,
    input  cache_pkg::beat_t                  data_rdata0,
    input  cache_pkg::beat_t                  data_rdata1,
    output logic                              resp_load,
    output logic                              mem_req_valid,
    output cache_pkg::mem_req_t               mem_req,
    input  logic                              mem_req_ready,
    output logic                              mem_req_data_valid,
    output cache_pkg::beat_t                  mem_req_data,
    input  logic                              mem_req_data_ready,
    input  logic                              mem_resp_valid,
    input  cache_pkg::beat_t                  mem_resp_data
);

    import cache_pkg::*;

    typedef enum logic [3:0] {
        S_INIT,     // clears meta one set per cycle
        S_IDLE,
        S_READ,     // memories read the captured index
        S_COMPARE,
        S_MERGE,    // byte merge of a write hit into its beat
        S_WB_REQ,
        S_WB_DATA,
        S_RF_REQ,
        S_RF_WAIT,
        S_RF_META
    } state_t;

    state_t                 state;
    cpu_req_t               req_q;
    logic                   way_q;  // way being merged, written back or refilled
    logic [`BEAT_BITS-1:0]  beat_cnt;
    logic [`INDEX_BITS-1:0] sweep_idx;
    logic                   is_write;
    logic [`TAG_BITS-1:0]   mem_tag;
    beat_t                  way_rdata;
    beat_t                  merged;

    assign cpu_req_ready = (state == S_IDLE);
    assign is_write      = |req_q.wmask;
    assign way_rdata     = way_q ? data_rdata1 : data_rdata0;
    assign resp_load     = (state == S_COMPARE) && lookup.hit && !is_write;

    always_ff @(posedge clk) begin
        if (cpu_req_ready && cpu_req_valid)
            req_q <= cpu_req;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_INIT;
            sweep_idx <= '0;
            beat_cnt  <= '0;
            way_q     <= 1'b0;
        end else begin
            case (state)
                S_INIT: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (&sweep_idx)
                        state <= S_IDLE;
                end
                S_IDLE: begin
                    if (cpu_req_valid)
                        state <= S_READ;
                end
                S_READ: begin
                    state <= S_COMPARE;
                end
                S_COMPARE: begin
                    beat_cnt <= '0;
                    if (lookup.hit) begin
                        way_q <= lookup.hit_way;
                        state <= is_write ? S_MERGE : S_IDLE;
                    end else begin
                        way_q <= lookup.victim_way;
                        state <= lookup.victim_dirty ? S_WB_REQ : S_RF_REQ;
                    end
                end
                S_MERGE: begin
                    state <= S_IDLE;
                end
                S_WB_REQ: begin
                    if (mem_req_ready)
                        state <= S_WB_DATA;
                end
                S_WB_DATA: begin
                    if (mem_req_data_ready) begin
                        beat_cnt <= beat_cnt + 1'b1; // wraps to 0 for the refill
                        state    <= (&beat_cnt) ? S_RF_REQ : S_WB_REQ;
                    end
                end
                S_RF_REQ: begin
                    if (mem_req_ready)
                        state <= S_RF_WAIT;
                end
                S_RF_WAIT: begin
                    if (mem_resp_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        state    <= (&beat_cnt) ? S_RF_META : S_RF_REQ;
                    end
                end
                S_RF_META: begin
                    state <= S_READ; // look up again, which now hits
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // meta memory is indexed by addr.index
    always_comb begin
        addr = req_q.addr;
        if (state == S_INIT)
            addr.index = sweep_idx;
    end

    always_comb begin
        data_index = {req_q.addr.index, req_q.addr.beat};
        if (state inside {S_WB_REQ, S_WB_DATA, S_RF_WAIT})
            data_index = {req_q.addr.index, beat_cnt};
    end

    // byte merge of the write word into its beat
    always_comb begin
        merged = way_rdata;
        for (int b = 0; b < `CPU_DATA_BITS / 8; b++) begin
            if (req_q.wmask[b])
                merged[req_q.addr.word * `CPU_DATA_BITS + b * 8 +: 8] = req_q.data[b * 8 +: 8];
        end
    end

    always_comb begin
        data_we    = '0;
        data_wdata = mem_resp_data;
        if (state == S_MERGE) begin
            data_we[way_q] = 1'b1;
            data_wdata     = merged;
        end else if (state == S_RF_WAIT && mem_resp_valid) begin
            data_we[way_q] = 1'b1;
        end
    end

    always_comb begin
        meta_we    = 1'b0;
        meta_wdata = meta_rdata;
        case (state)
            S_INIT: begin
                meta_we    = 1'b1;
                meta_wdata = '0;
            end
            S_COMPARE: begin
                meta_we        = lookup.hit;
                meta_wdata.lru = !lookup.hit_way; // other way is now oldest
            end
            S_MERGE: begin
                meta_we                     = 1'b1;
                meta_wdata.way[way_q].dirty = 1'b1;
            end
            S_RF_META: begin
                meta_we                     = 1'b1;
                meta_wdata.way[way_q].valid = 1'b1;
                meta_wdata.way[way_q].dirty = 1'b0;
                meta_wdata.way[way_q].tag   = req_q.addr.tag;
            end
            default: begin
                meta_we = 1'b0;
            end
        endcase
    end

    // write-back uses the victim's stored tag
    assign mem_tag            = (state == S_WB_REQ) ? meta_rdata.way[way_q].tag : req_q.addr.tag;
    assign mem_req_valid      = (state == S_WB_REQ) || (state == S_RF_REQ);
    assign mem_req.addr       = {mem_tag, req_q.addr.index, beat_cnt};
    assign mem_req.rw         = (state == S_WB_REQ);
    assign mem_req_data_valid = (state == S_WB_DATA);
    assign mem_req_data       = way_rdata;

endmodule

/* src/cache_result.sv */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_result (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  resp_load,
    input  logic                  hit_way,
    input  logic [`WORD_BITS-1:0] word_sel,
    input  cache_pkg::beat_t      data_rdata0,
    input  cache_pkg::beat_t      data_rdata1,
    output logic                  cpu_resp_valid,
    output cache_pkg::word_t      cpu_resp_data
);

    import cache_pkg::*;

    word_t [`WORDS_PER_BEAT-1:0] beat_words;
    word_t                       sel_word;

    assign beat_words = hit_way ? data_rdata1 : data_rdata0;
    assign sel_word   = beat_words[word_sel];

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            cpu_resp_valid <= 1'b0;
        else
            cpu_resp_valid <= resp_load; // single cycle pulse
    end

    always_ff @(posedge clk) begin
        if (resp_load)
            cpu_resp_data <= sel_word;
    end

endmodule

/* src/cache_top.sv */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                cpu_req_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic                cpu_req_ready,
    output logic                cpu_resp_valid,
    output cache_pkg::word_t    cpu_resp_data,
    output logic                mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_req_ready,
    output logic                mem_req_data_valid,
    output cache_pkg::beat_t    mem_req_data,
    input  logic                mem_req_data_ready,
    input  logic                mem_resp_valid,
    input  cache_pkg::beat_t    mem_resp_data
);

    import cache_pkg::*;

    addr_fields_t                      addr;
    lookup_t                           lookup;
    set_meta_t                         meta_rdata;
    set_meta_t                         meta_wdata;
    logic                              meta_we;
    logic [`INDEX_BITS+`BEAT_BITS-1:0] data_index;
    logic [`CACHE_WAYS-1:0]            data_we;
    beat_t                             data_wdata;
    beat_t                             data_rdata0;
    beat_t                             data_rdata1;
    logic                              resp_load;

    // one entry per set, both ways plus lru
    cache_sram #(
        .DEPTH     (`CACHE_SETS),
        .payload_t (set_meta_t)
    ) meta_mem (
        .clk   (clk),
        .we    (meta_we),
        .index (addr.index),
        .wdata (meta_wdata),
        .rdata (meta_rdata)
    );

    cache_sram #(
        .DEPTH     (`CACHE_SETS * `BEATS_PER_LINE),
        .payload_t (beat_t)
    ) data_mem0 (
        .clk   (clk),
        .we    (data_we[0]),
        .index (data_index),
        .wdata (data_wdata),
        .rdata (data_rdata0)
    );

    cache_sram #(
        .DEPTH     (`CACHE_SETS * `BEATS_PER_LINE),
        .payload_t (beat_t)
    ) data_mem1 (
        .clk   (clk),
        .we    (data_we[1]),
        .index (data_index),
        .wdata (data_wdata),
        .rdata (data_rdata1)
    );

    cache_decode u_decode (
        .addr   (addr),
        .meta   (meta_rdata),
        .lookup (lookup)
    );

    cache_execute u_execute (
        .clk                (clk),
        .reset              (reset),
        .cpu_req_valid      (cpu_req_valid),
        .cpu_req            (cpu_req),
        .cpu_req_ready      (cpu_req_ready),
        .addr               (addr),
        .lookup             (lookup),
        .meta_rdata         (meta_rdata),
        .meta_we            (meta_we),
        .meta_wdata         (meta_wdata),
        .data_index         (data_index),
        .data_we            (data_we),
        .data_wdata         (data_wdata),
        .data_rdata0        (data_rdata0),
        .data_rdata1        (data_rdata1),
        .resp_load          (resp_load),
        .mem_req_valid      (mem_req_valid),
        .mem_req            (mem_req),
        .mem_req_ready      (mem_req_ready),
        .mem_req_data_valid (mem_req_data_valid),
        .mem_req_data       (mem_req_data),
        .mem_req_data_ready (mem_req_data_ready),
        .mem_resp_valid     (mem_resp_valid),
        .mem_resp_data      (mem_resp_data)
    );

    cache_result u_result (
        .clk            (clk),
        .reset          (reset),
        .resp_load      (resp_load),
        .hit_way        (lookup.hit_way),
        .word_sel       (addr.word),
        .data_rdata0    (data_rdata0),
        .data_rdata1    (data_rdata1),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_data  (cpu_resp_data)
    );

endmodule

/* bench/cache_mem_model.sv */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_mem_model #(
    parameter logic [31:0] FILL = 32'h5A5A_C3C3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    output logic                mem_req_ready,
    input  logic                mem_req_data_valid,
    input  cache_pkg::beat_t    mem_req_data,
    output logic                mem_req_data_ready,
    output logic                mem_resp_valid,
    output cache_pkg::beat_t    mem_resp_data
);

    import cache_pkg::*;

    beat_t store [int]; // only beats that were written
    int    wr_addr;
    int    rd_addr;
    int    rd_wait;     // cycles left until the response strobe

    // unwritten words hold their word address xor FILL
    function automatic beat_t read_beat(input int ba);
        beat_t b;
        if (store.exists(ba))
            return store[ba];
        for (int i = 0; i < `WORDS_PER_BEAT; i++)
            b[i * `CPU_DATA_BITS +: `CPU_DATA_BITS] = word_t'(ba * `WORDS_PER_BEAT + i) ^ FILL;
        return b;
    endfunction

    function automatic word_t peek_word(input int wa);
        beat_t b;
        b = read_beat(wa / `WORDS_PER_BEAT);
        return b[(wa % `WORDS_PER_BEAT) * `CPU_DATA_BITS +: `CPU_DATA_BITS];
    endfunction

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_req_ready      <= 1'b0;
            mem_req_data_ready <= 1'b0;
            mem_resp_valid     <= 1'b0;
            mem_resp_data      <= '0;
            wr_addr            <= 0;
            rd_addr            <= 0;
            rd_wait            <= 0;
        end else begin
            mem_req_ready      <= ($urandom % 3) != 0; // random back-pressure
            mem_req_data_ready <= ($urandom % 3) != 0;
            mem_resp_valid     <= 1'b0;
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.rw) begin
                    wr_addr <= int'(mem_req.addr);
                end else begin
                    rd_addr <= int'(mem_req.addr);
                    rd_wait <= 1 + $urandom % 4;
                end
            end
            if (mem_req_data_valid && mem_req_data_ready)
                store[wr_addr] = mem_req_data;
            if (rd_wait != 0) begin
                rd_wait <= rd_wait - 1;
                if (rd_wait == 1) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_data  <= read_beat(rd_addr);
                end
            end
        end
    end

endmodule

/* bench/cache_tb.sv */
`timescale 1ns/10ps
`include "cache_defs.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int          CLK_PERIOD = 10;
    localparam logic [31:0] FILL       = 32'h5A5A_C3C3;
    localparam int          LINE_WORDS = `BEATS_PER_LINE * `WORDS_PER_BEAT;
    localparam int          TAG_SHIFT  = `INDEX_BITS + `BEAT_BITS + `WORD_BITS;
    localparam int          ACCESS_MAX = 200;  // cycles allowed for one access
    localparam int          NUM_RANDOM = 300;
    localparam int          NUM_ACCESS = NUM_RANDOM + 40; // directed tests use fewer than 40
    // twice the reset sweep plus every access at its limit
    localparam int          WATCHDOG_NS = 2 * CLK_PERIOD * (40 + NUM_ACCESS * ACCESS_MAX);

    logic     clk;
    logic     reset;
    logic     cpu_req_valid;
    cpu_req_t cpu_req;
    logic     cpu_req_ready;
    logic     cpu_resp_valid;
    word_t    cpu_resp_data;
    logic     mem_req_valid;
    mem_req_t mem_req;
    logic     mem_req_ready;
    logic     mem_req_data_valid;
    beat_t    mem_req_data;
    logic     mem_req_data_ready;
    logic     mem_resp_valid;
    beat_t    mem_resp_data;

    word_t ref_mem [int]; // words written by the cpu
    int    errors       = 0;
    int    checks       = 0;
    int    failed_tests = 0;
    word_t last_rdata;
    int    last_lat;      // edges after acceptance up to the one that ended the access
    logic  last_mem;      // mem_req_valid seen during the access

    cache_top UUT (.*);

    cache_mem_model #(.FILL(FILL)) mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    function automatic word_t ref_word(input int wa);
        return ref_mem.exists(wa) ? ref_mem[wa] : (word_t'(wa) ^ FILL);
    endfunction

    function automatic int line_base(input int tag, input int index);
        return (tag << TAG_SHIFT) | (index * LINE_WORDS);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // one cpu request and the wait for its response or for ready
    task automatic cpu_access(input int wa, input word_t wdata, input logic [3:0] wmask);
        int    cyc;
        logic  is_write;
        logic  done;
        word_t w;
        is_write = |wmask;
        @(posedge clk);
        cpu_req_valid <= 1'b1;
        cpu_req       <= '{addr: addr_fields_t'(`CACHE_ADDR_BITS'(wa)), data: wdata, wmask: wmask};
        cyc = 0;
        @(negedge clk);
        while (!cpu_req_ready && cyc < ACCESS_MAX) begin
            @(negedge clk);
            cyc++;
        end
        if (!cpu_req_ready) begin
            report_error($sformatf("request to word %h was never accepted", wa));
            @(posedge clk);
            cpu_req_valid <= 1'b0;
            return;
        end
        @(posedge clk); // accepted here
        cpu_req_valid <= 1'b0;
        if (is_write) begin
            w = ref_word(wa);
            for (int b = 0; b < `CPU_DATA_BITS / 8; b++)
                if (wmask[b])
                    w[b * 8 +: 8] = wdata[b * 8 +: 8];
            ref_mem[wa] = w;
        end
        done     = 1'b0;
        last_lat = 0;
        last_mem = 1'b0;
        while (!done && last_lat < ACCESS_MAX) begin
            @(negedge clk);
            last_lat++;
            last_mem |= mem_req_valid;
            done = is_write ? cpu_req_ready : cpu_resp_valid;
        end
        if (!done)
            report_error($sformatf("access to word %h did not complete", wa));
        last_rdata = cpu_resp_data;
        last_lat--;
    endtask

    task automatic read_expect(input int wa);
        cpu_access(wa, '0, 4'b0000);
        check($sformatf("cpu_resp_data @%h", wa), last_rdata, ref_word(wa));
    endtask

    task automatic end_test(input string name, input int err0);
        if (errors == err0) begin
            $display("test %-12s ok", name);
        end else begin
            failed_tests++;
            $display("test %-12s %0d errors", name, errors - err0);
        end
    endtask

    task automatic reset_and_sweep();
        int cyc;
        @(negedge clk);
        check("cpu_resp_valid", int'(cpu_resp_valid), 0);
        check("mem_req_valid", int'(mem_req_valid), 0);
        check("mem_req_data_valid", int'(mem_req_data_valid), 0);
        cyc = 0;
        while (!cpu_req_ready && cyc < 40) begin
            @(negedge clk);
            cyc++;
        end
        if (!cpu_req_ready)
            report_error("cpu_req_ready did not rise within 40 cycles of reset");
    endtask

    task automatic read_miss_then_hit();
        int wa;
        wa = line_base(5, 3) + 6;
        read_expect(wa);      // cold miss with refill
        read_expect(wa + 1);  // same line
        check("read hit latency", last_lat, 2);
        check("mem_req_valid on hit", int'(last_mem), 0);
    endtask

    task automatic byte_masked_writes();
        int wa;
        wa = line_base(9, 4) + 10;
        cpu_access(wa, 32'hA1B2_C3D4, 4'b0101); // write miss with allocate
        read_expect(wa);
        cpu_access(wa, 32'h1122_3344, 4'b1010);
        check("write hit latency", last_lat, 3);
        read_expect(wa);
        cpu_access(wa + 3, 32'hDEAD_BEEF, 4'b1000);
        read_expect(wa + 3);
        cpu_access(line_base(9, 5) + 1, 32'hCAFE_F00D, 4'b0011);
        read_expect(line_base(9, 5) + 1);
    endtask

    task automatic dirty_eviction();
        int base;
        base = line_base(1, 7);
        for (int i = 0; i < LINE_WORDS; i += 5)
            cpu_access(base + i, $urandom, 4'b1111);
        cpu_access(line_base(2, 7), 32'h0BAD_F00D, 4'b1111);
        cpu_access(line_base(3, 7) + 2, 32'h1234_5678, 4'b0110); // evicts the first line
        for (int i = 0; i < LINE_WORDS; i++)
            check($sformatf("memory word @%h", base + i), mem_model.peek_word(base + i),
                  ref_word(base + i));
        for (int i = 0; i < LINE_WORDS; i += 5)
            read_expect(base + i);
    endtask

    task automatic lru_replacement();
        int a;
        int b;
        int c;
        a = line_base(4, 12);
        b = line_base(5, 12);
        c = line_base(6, 12);
        read_expect(a);
        read_expect(b);
        read_expect(a);
        read_expect(c);  // b is least recent
        read_expect(a);
        check("mem_req_valid on line A", int'(last_mem), 0);
        read_expect(b);
        check("mem_req_valid on line B", int'(last_mem), 1);
    endtask

    task automatic random_traffic();
        int         wa;
        logic [3:0] m;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            wa = line_base(8 + $urandom % 4, 20 + $urandom % 2) + $urandom % LINE_WORDS;
            if ($urandom % 2 != 0) begin
                m = 4'($urandom % 15 + 1);
                cpu_access(wa, $urandom, m);
            end else begin
                read_expect(wa);
            end
        end
    endtask

    initial begin
        int err0;
        void'($urandom(20224));
        reset         = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        err0 = errors;
        reset_and_sweep();
        end_test("reset", err0);
        err0 = errors;
        read_miss_then_hit();
        end_test("read_hit", err0);
        err0 = errors;
        byte_masked_writes();
        end_test("byte_writes", err0);
        err0 = errors;
        dirty_eviction();
        end_test("evict", err0);
        err0 = errors;
        lru_replacement();
        end_test("lru", err0);
        err0 = errors;
        random_traffic();
        end_test("random", err0);

        $display("checks %0d, errors %0d, failed tests %0d", checks, errors, failed_tests);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* cache.f */
+incdir+.
src/cache_pkg.sv
src/cache_sram.sv
src/cache_decode.sv
src/cache_execute.sv
src/cache_result.sv
src/cache_top.sv
bench/cache_mem_model.sv
bench/cache_tb.sv

/* Makefile */
# Verilator flow for the cache testbench
# any variable can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) cache_defs.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Simulation passed" $(LOG) || { echo "FAIL, see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
